/* run_sim.sh */
#!/usr/bin/env bash
# builds the colour correction testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=ccm_sim
LOG_FILE=sim.log

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module ccm_tb \
    --Mdir "$BUILD_DIR" \
    -o "$SIM_BIN" \
    -f sim.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "build failed with status $build_status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Finished with errors" "$LOG_FILE"; then
    echo "simulation reported failures"
    exit 1
fi

if ! grep -q "Finished with no errors" "$LOG_FILE"; then
    echo "simulation ended without a result line"
    exit 1
fi

exit 0

/* sim.f */
verilog/ccm_pkg.sv
verilog/ccm_coe_bank.sv
verilog/ccm_matrix.sv
verilog/ccm_top.sv
sim/ccm_check.sv
sim/ccm_tb.sv

/* sim/ccm_check.sv */
// reference model and output assertions for the colour correction top level
`default_nettype none

module ccm_check (
    input  wire logic                                  clk,
    input  wire logic                                  rst_n_i,

    // host writes, as seen by the DUT
    input  wire logic                                  coe_we_i,
    input  wire logic [ccm_pkg::COE_ADDR_WIDTH-1:0]    coe_addr_i,
    input  wire logic [ccm_pkg::COE_WIDTH-1:0]         coe_data_i,

    // video into and out of the DUT
    input  wire logic [ccm_pkg::PIXEL_BUS_WIDTH-1:0]   di_i,
    input  wire logic                                  de_i,
    input  wire logic                                  hs_i,
    input  wire logic                                  vs_i,
    input  wire logic [ccm_pkg::PIXEL_BUS_WIDTH-1:0]   do_i,
    input  wire logic                                  de_o_i,
    input  wire logic                                  hs_o_i,
    input  wire logic                                  vs_o_i,

    // test running when a sample enters
    input  wire logic [2:0]                            test_id_i,

    output int                                         err_count_o,
    output int                                         pixel_count_o
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int LAST = ccm_pkg::PIPE_LATENCY - 1;

    // mirrored coefficient sets
    logic [ccm_pkg::COE_WIDTH-1:0] pend_m [ccm_pkg::COE_COUNT];
    logic [ccm_pkg::COE_WIDTH-1:0] act_m  [ccm_pkg::COE_COUNT];
    logic                          vs_m;

    // expected outputs, one entry per pipeline stage
    logic [ccm_pkg::PIXEL_BUS_WIDTH-1:0] exp_pix  [ccm_pkg::PIPE_LATENCY];
    logic [2:0]                          exp_sync [ccm_pkg::PIPE_LATENCY];
    logic [2:0]                          exp_test [ccm_pkg::PIPE_LATENCY];

    logic started = 1'b0;
    int   pix_errors = 0;
    int   de_errors = 0;
    int   hs_errors = 0;
    int   vs_errors = 0;
    int   pixels_seen = 0;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1:    return "identity";
            3'd2:    return "rounding";
            3'd3:    return "clip_high";
            3'd4:    return "clip_low_hold";
            3'd5:    return "new_set";
            default: return "reset";
        endcase
    endfunction

    // diagonal entries c0, c4 and c8 hold 1.0
    function automatic logic [ccm_pkg::COE_WIDTH-1:0] identity_coe(input int k);
        if (k == 0 || k == 4 || k == 8) begin
            return ccm_pkg::COE_ONE;
        end
        return '0;
    endfunction

    // Q4.10 value from the low 14 bits
    function automatic int coe_value(input logic [ccm_pkg::COE_WIDTH-1:0] c);
        logic signed [ccm_pkg::COE_USED_WIDTH-1:0] v;
        v = c[ccm_pkg::COE_USED_WIDTH-1:0];
        return int'(v);
    endfunction

    // row sum, round to nearest, clip to 0..255
    function automatic logic [ccm_pkg::PIXEL_BUS_WIDTH-1:0] expected_pixel(
        input logic [ccm_pkg::PIXEL_BUS_WIDTH-1:0] pix
    );
        int sum;
        int comp;
        logic [ccm_pkg::PIXEL_BUS_WIDTH-1:0] result;
        result = '0;
        for (int r = 0; r < ccm_pkg::COMP_COUNT; r++) begin
            sum = 0;
            for (int c = 0; c < ccm_pkg::COMP_COUNT; c++) begin
                sum += coe_value(act_m[r*ccm_pkg::COMP_COUNT + c]) *
                       int'(pix[c*ccm_pkg::PIXEL_WIDTH +: ccm_pkg::PIXEL_WIDTH]);
            end
            sum += int'(ccm_pkg::ROUND_HALF);
            if (sum < 0) begin
                comp = 0;
            end else begin
                comp = sum >>> ccm_pkg::COE_FRACTION_WIDTH;
                if (comp > 255) begin
                    comp = 255;
                end
            end
            result[r*ccm_pkg::PIXEL_WIDTH +: ccm_pkg::PIXEL_WIDTH] = comp[7:0];
        end
        return result;
    endfunction

    // --------------------------------------------------
    // model, expected values use the set before this edge
    // --------------------------------------------------
    always @(posedge clk) begin
        started <= 1'b1;
        if (!rst_n_i) begin
            vs_m <= 1'b0;
            for (int k = 0; k < ccm_pkg::COE_COUNT; k++) begin
                pend_m[k] <= identity_coe(k);
                act_m[k]  <= identity_coe(k);
            end
            for (int s = 0; s < ccm_pkg::PIPE_LATENCY; s++) begin
                exp_pix[s]  <= '0;
                exp_sync[s] <= 3'b000;
                exp_test[s] <= 3'd0;
            end
        end else begin
            exp_pix[0]  <= expected_pixel(di_i);
            exp_sync[0] <= {vs_i, hs_i, de_i};
            exp_test[0] <= test_id_i;
            for (int s = 1; s < ccm_pkg::PIPE_LATENCY; s++) begin
                exp_pix[s]  <= exp_pix[s-1];
                exp_sync[s] <= exp_sync[s-1];
                exp_test[s] <= exp_test[s-1];
            end
            vs_m <= vs_i;
            if (vs_i && !vs_m) begin
                for (int k = 0; k < ccm_pkg::COE_COUNT; k++) begin
                    act_m[k] <= pend_m[k];
                end
            end
            if (coe_we_i && (coe_addr_i < ccm_pkg::COE_COUNT)) begin
                pend_m[coe_addr_i] <= coe_data_i;
            end
        end
    end

    // --------------------------------------------------
    // output checks, away from the active edge
    // --------------------------------------------------
    pixel_check: assert property (@(negedge clk)
        !started || !exp_sync[LAST][0] || (do_i === exp_pix[LAST]))
    else begin
        pix_errors++;
        $display("mismatch %s do_o: expected %h actual %h",
                 test_name(exp_test[LAST]), exp_pix[LAST], do_i);
    end

    de_check: assert property (@(negedge clk) !started || (de_o_i === exp_sync[LAST][0]))
    else begin
        de_errors++;
        $display("mismatch %s de_o: expected %b actual %b",
                 test_name(exp_test[LAST]), exp_sync[LAST][0], de_o_i);
    end

    hs_check: assert property (@(negedge clk) !started || (hs_o_i === exp_sync[LAST][1]))
    else begin
        hs_errors++;
        $display("mismatch %s hs_o: expected %b actual %b",
                 test_name(exp_test[LAST]), exp_sync[LAST][1], hs_o_i);
    end

    vs_check: assert property (@(negedge clk) !started || (vs_o_i === exp_sync[LAST][2]))
    else begin
        vs_errors++;
        $display("mismatch %s vs_o: expected %b actual %b",
                 test_name(exp_test[LAST]), exp_sync[LAST][2], vs_o_i);
    end

    // pixels that reached the compare
    always @(negedge clk) begin
        if (started && exp_sync[LAST][0]) begin
            pixels_seen++;
        end
    end

    assign err_count_o = pix_errors + de_errors + hs_errors + vs_errors;
    assign pixel_count_o = pixels_seen;

endmodule

`default_nettype wire

/* sim/ccm_tb.sv */
// testbench for the colour correction top level, frames and coefficient writes
`default_nettype none

module ccm_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // --------------------------------------------------
    // stimulus timing
    // --------------------------------------------------
    localparam int CLK_HALF = 10;
    localparam int RESET_CYCLES = 10;
    localparam int FRAME_COUNT = 5;
    localparam int VS_CYCLES = 2;
    localparam int V_BLANK = 4;
    localparam int LINES = 4;
    localparam int PIXELS = 16;
    localparam int H_BLANK = 12;
    localparam int HS_START = 4;
    localparam int HS_CYCLES = 4;
    localparam int LINE_CYCLES = PIXELS + H_BLANK;
    localparam int FRAME_CYCLES = VS_CYCLES + V_BLANK + LINES * LINE_CYCLES;
    localparam int WRITE_CYCLES = ccm_pkg::COE_COUNT + 2;
    localparam int STIM_CYCLES = RESET_CYCLES + FRAME_COUNT * FRAME_CYCLES
                               + 3 * WRITE_CYCLES + 20;
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;
    localparam int EXPECTED_PIXELS = FRAME_COUNT * LINES * PIXELS;

    // 3.9 and -1.0 in Q4.10
    // -1.0 leaves bits 15:14 clear, only the low 14 bits count
    localparam logic [15:0] COE_CLIP_HIGH = 16'd3994;
    localparam logic [15:0] COE_MINUS_ONE = 16'h3c00;

    logic        clk;
    logic        rst_n;
    logic        coe_we;
    logic [3:0]  coe_addr;
    logic [15:0] coe_data;
    logic [23:0] di;
    logic        de;
    logic        hs;
    logic        vs;
    logic [23:0] do_w;
    logic        de_w;
    logic        hs_w;
    logic        vs_w;
    logic [2:0]  test_id;

    logic [15:0] coe_set [ccm_pkg::COE_COUNT];
    int          seed = 32'h027a_bdc1;
    int          cycle_count;
    int          other_errors;
    int          check_errors;
    int          pixels_checked;

    ccm_top u_dut (
        .clk        (clk),
        .rst_n_i    (rst_n),
        .coe_we_i   (coe_we),
        .coe_addr_i (coe_addr),
        .coe_data_i (coe_data),
        .di_i       (di),
        .de_i       (de),
        .hs_i       (hs),
        .vs_i       (vs),
        .do_o       (do_w),
        .de_o       (de_w),
        .hs_o       (hs_w),
        .vs_o       (vs_w)
    );

    ccm_check u_check (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .coe_we_i      (coe_we),
        .coe_addr_i    (coe_addr),
        .coe_data_i    (coe_data),
        .di_i          (di),
        .de_i          (de),
        .hs_i          (hs),
        .vs_i          (vs),
        .do_i          (do_w),
        .de_o_i        (de_w),
        .hs_o_i        (hs_w),
        .vs_o_i        (vs_w),
        .test_id_i     (test_id),
        .err_count_o   (check_errors),
        .pixel_count_o (pixels_checked)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    // run limit
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: stimulus did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    function automatic logic [23:0] random_pixel(input logic bright);
        logic [23:0] p;
        p = 24'($random(seed));
        if (bright) begin
            p = p | 24'h808080;
        end
        return p;
    endfunction

    task automatic drive_cycle(input logic [23:0] pix, input logic de_l,
                               input logic hs_l, input logic vs_l);
        @(negedge clk);
        di = pix;
        de = de_l;
        hs = hs_l;
        vs = vs_l;
    endtask

    // one vs pulse, blanking, then lines with hs between them
    task automatic send_frame(input logic bright);
        logic hs_l;
        for (int v = 0; v < VS_CYCLES; v++) begin
            drive_cycle(24'h0, 1'b0, 1'b0, 1'b1);
        end
        for (int v = 0; v < V_BLANK; v++) begin
            drive_cycle(24'h0, 1'b0, 1'b0, 1'b0);
        end
        for (int l = 0; l < LINES; l++) begin
            for (int p = 0; p < PIXELS; p++) begin
                drive_cycle(random_pixel(bright), 1'b1, 1'b0, 1'b0);
            end
            for (int b = 0; b < H_BLANK; b++) begin
                hs_l = (l < LINES - 1) && (b >= HS_START) && (b < HS_START + HS_CYCLES);
                drive_cycle(24'h0, 1'b0, hs_l, 1'b0);
            end
        end
    endtask

    task automatic write_coe(input logic [3:0] addr, input logic [15:0] data);
        @(negedge clk);
        coe_we = 1'b1;
        coe_addr = addr;
        coe_data = data;
    endtask

    task automatic end_writes();
        @(negedge clk);
        coe_we = 1'b0;
    endtask

    task automatic write_set();
        for (int k = 0; k < ccm_pkg::COE_COUNT; k++) begin
            write_coe(4'(k), coe_set[k]);
        end
    endtask

    // -2.0 .. 2.0 in Q4.10
    task automatic fill_random_set();
        for (int k = 0; k < ccm_pkg::COE_COUNT; k++) begin
            coe_set[k] = 16'($random(seed) % 2049);
        end
    endtask

    task automatic fill_constant_set(input logic [15:0] value);
        for (int k = 0; k < ccm_pkg::COE_COUNT; k++) begin
            coe_set[k] = value;
        end
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        rst_n = 1'b0;
        coe_we = 1'b0;
        coe_addr = 4'd0;
        coe_data = 16'd0;
        di = 24'h0;
        de = 1'b0;
        hs = 1'b0;
        vs = 1'b0;
        test_id = 3'd0;
        other_errors = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(negedge clk);

        test_id = 3'd1;
        send_frame(1'b0);

        test_id = 3'd2;
        fill_random_set();
        write_set();
        end_writes();
        send_frame(1'b0);

        test_id = 3'd3;
        fill_constant_set(COE_CLIP_HIGH);
        write_set();
        end_writes();
        send_frame(1'b1);

        // negative set now and a new set written during the frame
        test_id = 3'd4;
        fill_constant_set(COE_MINUS_ONE);
        write_set();
        end_writes();
        fill_random_set();
        fork
            send_frame(1'b1);
            begin
                repeat (VS_CYCLES + V_BLANK + LINE_CYCLES + 6) @(negedge clk);
                write_set();
                write_coe(4'd12, 16'h1234);
                end_writes();
            end
        join

        test_id = 3'd5;
        send_frame(1'b0);
        repeat (ccm_pkg::PIPE_LATENCY + 3) @(negedge clk);

        if (pixels_checked != EXPECTED_PIXELS) begin
            other_errors++;
            $display("only %0d of %0d output pixels were compared",
                     pixels_checked, EXPECTED_PIXELS);
        end
        $display("errors: %0d output mismatches, %0d other failures",
                 check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/ccm_coe_bank.sv */
// coefficient bank with pending set and frame-synchronous active set
`default_nettype none

module ccm_coe_bank (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n_i,

    // host write port
    input  wire logic                                 coe_we_i,
    input  wire logic [ccm_pkg::COE_ADDR_WIDTH-1:0]   coe_addr_i,
    input  wire logic [ccm_pkg::COE_WIDTH-1:0]        coe_data_i,

    // vertical sync of the incoming video
    input  wire logic                                 vs_i,

    // active coefficients, c0 in the low bits
    output logic      [ccm_pkg::COE_BUS_WIDTH-1:0]    coe_o
);

    logic [ccm_pkg::COE_WIDTH-1:0] coe_pend [ccm_pkg::COE_COUNT];
    logic [ccm_pkg::COE_WIDTH-1:0] coe_act  [ccm_pkg::COE_COUNT];
    logic                          vs_q;
    logic                          frame_start;

    // --------------------------------------------------
    // frame start detect
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            vs_q <= 1'b0;
        end else begin
            vs_q <= vs_i;
        end
    end

    // first cycle of vs high
    assign frame_start = vs_i & ~vs_q;

    // --------------------------------------------------
    // pending set
    // --------------------------------------------------
    // addresses 9..15 match no register and are dropped
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int k = 0; k < ccm_pkg::COE_COUNT; k++) begin
                coe_pend[k] <= ccm_pkg::COE_IDENTITY[k*ccm_pkg::COE_WIDTH +: ccm_pkg::COE_WIDTH];
            end
        end else begin
            for (int k = 0; k < ccm_pkg::COE_COUNT; k++) begin
                if (coe_we_i && (coe_addr_i == ccm_pkg::COE_ADDR_WIDTH'(k))) begin
                    coe_pend[k] <= coe_data_i;
                end
            end
        end
    end

    // --------------------------------------------------
    // active set
    // --------------------------------------------------
    // copies the pending values as they stood before this edge,
    // so a write on the frame start edge waits for the next frame
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int k = 0; k < ccm_pkg::COE_COUNT; k++) begin
                coe_act[k] <= ccm_pkg::COE_IDENTITY[k*ccm_pkg::COE_WIDTH +: ccm_pkg::COE_WIDTH];
            end
        end else if (frame_start) begin
            for (int k = 0; k < ccm_pkg::COE_COUNT; k++) begin
                coe_act[k] <= coe_pend[k];
            end
        end
    end

    // flatten for the matrix
    always_comb begin
        for (int k = 0; k < ccm_pkg::COE_COUNT; k++) begin
            coe_o[k*ccm_pkg::COE_WIDTH +: ccm_pkg::COE_WIDTH] = coe_act[k];
        end
    end

endmodule

`default_nettype wire

/* verilog/ccm_matrix.sv */
// 3x3 colour matrix pipeline with rounding, clipping and aligned sync levels
`default_nettype none

module ccm_matrix (
    input  wire logic                                  clk,
    input  wire logic                                  rst_n_i,

    // active coefficients, c0 in the low bits
    input  wire logic [ccm_pkg::COE_BUS_WIDTH-1:0]     coe_i,

    // R in 7:0, G in 15:8, B in 23:16
    input  wire logic [ccm_pkg::PIXEL_BUS_WIDTH-1:0]   di_i,
    input  wire logic                                  de_i,
    input  wire logic                                  hs_i,
    input  wire logic                                  vs_i,

    output logic      [ccm_pkg::PIXEL_BUS_WIDTH-1:0]   do_o,
    output logic                                       de_o,
    output logic                                       hs_o,
    output logic                                       vs_o
);

    localparam int ZERO_FILL = ccm_pkg::COE_USED_WIDTH - ccm_pkg::PIXEL_WIDTH;
    localparam int OVERFLOW_LSB = ccm_pkg::COE_FRACTION_WIDTH + ccm_pkg::PIXEL_WIDTH;
    localparam int SYNC_DEPTH = ccm_pkg::PIPE_LATENCY - 1;

    // unpacked operands
    logic signed [ccm_pkg::COE_USED_WIDTH-1:0] coe     [ccm_pkg::COE_COUNT];
    logic signed [ccm_pkg::COE_USED_WIDTH-1:0] pix_ext [ccm_pkg::COMP_COUNT];

    // stage 0
    logic signed [ccm_pkg::PRODUCT_WIDTH-1:0]  prod    [ccm_pkg::COE_COUNT];
    // stage 1
    logic signed [ccm_pkg::PAIR_WIDTH-1:0]     pair    [ccm_pkg::COMP_COUNT];
    logic signed [ccm_pkg::PRODUCT_WIDTH-1:0]  third   [ccm_pkg::COMP_COUNT];
    // stage 2
    logic signed [ccm_pkg::SUM_WIDTH-1:0]      sum     [ccm_pkg::COMP_COUNT];
    // stage 3
    logic signed [ccm_pkg::ROUND_WIDTH-1:0]    rnd     [ccm_pkg::COMP_COUNT];

    // {vs, hs, de} per stage
    logic [2:0] sync_sr [SYNC_DEPTH];

    // --------------------------------------------------
    // operand unpacking
    // --------------------------------------------------
    always_comb begin
        for (int k = 0; k < ccm_pkg::COE_COUNT; k++) begin
            // only the low 14 bits carry the Q4.10 value
            coe[k] = coe_i[k*ccm_pkg::COE_WIDTH +: ccm_pkg::COE_USED_WIDTH];
        end
        for (int c = 0; c < ccm_pkg::COMP_COUNT; c++) begin
            pix_ext[c] = {{ZERO_FILL{1'b0}}, di_i[c*ccm_pkg::PIXEL_WIDTH +: ccm_pkg::PIXEL_WIDTH]};
        end
    end

    // --------------------------------------------------
    // arithmetic stages 0..3
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        // stage 0, nine products
        for (int r = 0; r < ccm_pkg::COMP_COUNT; r++) begin
            for (int c = 0; c < ccm_pkg::COMP_COUNT; c++) begin
                prod[r*ccm_pkg::COMP_COUNT + c] <= coe[r*ccm_pkg::COMP_COUNT + c] * pix_ext[c];
            end
        end

        for (int r = 0; r < ccm_pkg::COMP_COUNT; r++) begin
            // stage 1, first two terms of the row
            pair[r]  <= prod[r*ccm_pkg::COMP_COUNT] + prod[r*ccm_pkg::COMP_COUNT + 1];
            third[r] <= prod[r*ccm_pkg::COMP_COUNT + 2];

            // stage 2, full row sum
            sum[r] <= pair[r] + third[r];

            // stage 3, round to nearest
            rnd[r] <= sum[r] + ccm_pkg::ROUND_HALF;
        end
    end

    // --------------------------------------------------
    // stage 4, clip to 0..255
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        for (int r = 0; r < ccm_pkg::COMP_COUNT; r++) begin
            if (rnd[r][ccm_pkg::ROUND_WIDTH-1]) begin
                // negative result
                do_o[r*ccm_pkg::PIXEL_WIDTH +: ccm_pkg::PIXEL_WIDTH] <= '0;
            end else if (|rnd[r][ccm_pkg::ROUND_WIDTH-2:OVERFLOW_LSB]) begin
                // above 255 after the shift
                do_o[r*ccm_pkg::PIXEL_WIDTH +: ccm_pkg::PIXEL_WIDTH] <= '1;
            end else begin
                do_o[r*ccm_pkg::PIXEL_WIDTH +: ccm_pkg::PIXEL_WIDTH] <=
                    rnd[r][ccm_pkg::COE_FRACTION_WIDTH +: ccm_pkg::PIXEL_WIDTH];
            end
        end
    end

    // --------------------------------------------------
    // sync level delay
    // --------------------------------------------------
    // four stages here plus the output register match the data path
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int s = 0; s < SYNC_DEPTH; s++) begin
                sync_sr[s] <= 3'b000;
            end
            de_o <= 1'b0;
            hs_o <= 1'b0;
            vs_o <= 1'b0;
        end else begin
            sync_sr[0] <= {vs_i, hs_i, de_i};
            for (int s = 1; s < SYNC_DEPTH; s++) begin
                sync_sr[s] <= sync_sr[s-1];
            end
            de_o <= sync_sr[SYNC_DEPTH-1][0];
            hs_o <= sync_sr[SYNC_DEPTH-1][1];
            vs_o <= sync_sr[SYNC_DEPTH-1][2];
        end
    end

endmodule

`default_nettype wire

/* verilog/ccm_pkg.sv */
// colour correction matrix shared widths, coefficient format and latency
`default_nettype none

package ccm_pkg;

    // --------------------------------------------------
    // pixel format
    // --------------------------------------------------
    localparam int PIXEL_WIDTH = 8;
    // r, g and b components per pixel
    localparam int COMP_COUNT = 3;
    localparam int PIXEL_BUS_WIDTH = PIXEL_WIDTH * COMP_COUNT;

    // --------------------------------------------------
    // coefficient format, signed Q4.10
    // --------------------------------------------------
    localparam int COE_WIDTH = 16;
    localparam int COE_USED_WIDTH = 14;
    localparam int COE_FRACTION_WIDTH = 10;
    // row order r' = c0..c2, g' = c3..c5, b' = c6..c8
    localparam int COE_COUNT = 9;
    localparam int COE_ADDR_WIDTH = 4;
    localparam int COE_BUS_WIDTH = COE_WIDTH * COE_COUNT;

    // 1.0 in Q4.10
    localparam logic [COE_WIDTH-1:0] COE_ONE = 16'd1024;

    // identity matrix, c0 in the low bits
    localparam logic [COE_BUS_WIDTH-1:0] COE_IDENTITY = {
        COE_ONE, 16'd0, 16'd0,
        16'd0, COE_ONE, 16'd0,
        16'd0, 16'd0, COE_ONE
    };

    // --------------------------------------------------
    // arithmetic widths through the pipeline
    // --------------------------------------------------
    localparam int PRODUCT_WIDTH = 2 * COE_USED_WIDTH;
    localparam int PAIR_WIDTH = PRODUCT_WIDTH + 1;
    localparam int SUM_WIDTH = PAIR_WIDTH + 1;
    localparam int ROUND_WIDTH = SUM_WIDTH + 1;

    // 0.5 in Q4.10, added before truncation
    localparam logic signed [ROUND_WIDTH-1:0] ROUND_HALF = 31'sd512;

    // pixel latency through the matrix in clock cycles
    localparam int PIPE_LATENCY = 5;

endpackage

`default_nettype wire

/* verilog/ccm_top.sv */
// colour correction top level, coefficient bank feeding the matrix pipeline
`default_nettype none

module ccm_top (
    input  wire logic                                  clk,
    input  wire logic                                  rst_n_i,

    // host coefficient writes
    input  wire logic                                  coe_we_i,
    input  wire logic [ccm_pkg::COE_ADDR_WIDTH-1:0]    coe_addr_i,
    input  wire logic [ccm_pkg::COE_WIDTH-1:0]         coe_data_i,

    // video in
    input  wire logic [ccm_pkg::PIXEL_BUS_WIDTH-1:0]   di_i,
    input  wire logic                                  de_i,
    input  wire logic                                  hs_i,
    input  wire logic                                  vs_i,

    // video out, five cycles later
    output logic      [ccm_pkg::PIXEL_BUS_WIDTH-1:0]   do_o,
    output logic                                       de_o,
    output logic                                       hs_o,
    output logic                                       vs_o
);

    // active coefficient set
    logic [ccm_pkg::COE_BUS_WIDTH-1:0] coe_bus;

    // --------------------------------------------------
    // coefficient bank
    // --------------------------------------------------
    ccm_coe_bank u_coe_bank (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .coe_we_i   (coe_we_i),
        .coe_addr_i (coe_addr_i),
        .coe_data_i (coe_data_i),
        .vs_i       (vs_i),
        .coe_o      (coe_bus)
    );

    // --------------------------------------------------
    // matrix pipeline
    // --------------------------------------------------
    ccm_matrix u_matrix (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .coe_i   (coe_bus),
        .di_i    (di_i),
        .de_i    (de_i),
        .hs_i    (hs_i),
        .vs_i    (vs_i),
        .do_o    (do_o),
        .de_o    (de_o),
        .hs_o    (hs_o),
        .vs_o    (vs_o)
    );

endmodule

`default_nettype wire
